//--- logic/draw_pkg.sv
package draw_pkg;

    // Frame buffer geometry
    parameter int SCREEN_W = 160;
    parameter int SCREEN_H = 120;

    // Screen coordinates and colour
    typedef logic [7:0] x_coord_t;
    typedef logic [6:0] y_coord_t;
    typedef logic [2:0] colour_t;

    // Diameter, also used as the circle radius
    typedef logic [7:0] dim_t;

    // Corners may fall off screen, so they carry a sign
    typedef logic signed [8:0] corner_x_t;
    typedef logic signed [7:0] corner_y_t;

    // One pixel strobe towards the frame buffer
    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
        logic     plot;
    } pixel_t;

    typedef struct packed {
        corner_x_t x;
        corner_y_t y;
    } corner_t;

    // c1 bottom right, c2 bottom left, c3 top
    typedef struct packed {
        corner_t c1;
        corner_t c2;
        corner_t c3;
    } corners_t;

    // Which bounding arc is being drawn
    typedef enum logic [1:0] {
        ARC_NONE,
        ARC_1,
        ARC_2,
        ARC_3
    } arc_t;

endpackage

//--- logic/fillscreen.sv
`timescale 1ns/1ps

module fillscreen (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output logic             done,
    output draw_pkg::pixel_t pixel
);

    typedef enum logic {
        F_SWEEP,
        F_FINISHED
    } fill_state_t;

    fill_state_t        state;
    draw_pkg::x_coord_t col;
    draw_pkg::y_coord_t row;

    // Column-major sweep, rows inner
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= F_SWEEP;
            col   <= '0;
            row   <= '0;
        end else if (!start) begin
            // Rearm for the next clear
            state <= F_SWEEP;
            col   <= '0;
            row   <= '0;
        end else if (state == F_SWEEP) begin
            if (row == draw_pkg::y_coord_t'(draw_pkg::SCREEN_H - 1)) begin
                row <= '0;
                if (col == draw_pkg::x_coord_t'(draw_pkg::SCREEN_W - 1)) begin
                    col   <= '0;
                    state <= F_FINISHED;
                end else begin
                    col <= col + 8'd1;
                end
            end else begin
                row <= row + 7'd1;
            end
        end
    end

    // Plot every cycle of the sweep
    assign pixel.x    = col;
    assign pixel.y    = row;
    assign pixel.plot = start && (state == F_SWEEP);
    assign done       = (state == F_FINISHED);

endmodule

//--- logic/circle.sv
`timescale 1ns/1ps

module circle (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  draw_pkg::corner_t centre,
    input  draw_pkg::dim_t    radius,
    output logic              done,
    output draw_pkg::pixel_t  pixel
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_PLOT,
        C_DONE
    } circle_state_t;

    circle_state_t      state;
    logic signed [9:0]  off_x;
    logic signed [9:0]  off_y;
    logic signed [11:0] crit;
    logic [2:0]         octant;

    logic signed [9:0]  next_x;
    logic signed [9:0]  next_y;
    logic signed [9:0]  step_diff;
    logic signed [11:0] next_crit;

    logic signed [9:0]  swap_a;
    logic signed [9:0]  swap_b;
    logic signed [9:0]  dx;
    logic signed [9:0]  dy;
    logic signed [10:0] px;
    logic signed [10:0] py;
    logic               on_screen;

    // Midpoint step, applied after the eighth octant point
    always_comb begin
        next_y = off_y + 10'sd1;
        if (crit <= 12'sd0) begin
            next_x    = off_x;
            step_diff = next_y;
        end else begin
            next_x    = off_x - 10'sd1;
            step_diff = next_y - next_x;
        end
        // 2*step_diff + 1 in both branches
        next_crit = crit + $signed({step_diff[9], step_diff, 1'b1});
    end

    // Octant bit 0 swaps the offsets, bits 2:1 pick the signs
    always_comb begin
        swap_a = octant[0] ? off_y : off_x;
        swap_b = octant[0] ? off_x : off_y;
        dx     = (octant[2] ^ octant[1]) ? -swap_a : swap_a;
        dy     = octant[2] ? -swap_b : swap_b;

        px = $signed({{2{centre.x[8]}}, centre.x}) + $signed({dx[9], dx});
        py = $signed({{3{centre.y[7]}}, centre.y}) + $signed({dy[9], dy});

        on_screen = (px >= 11'sd0) && (px < draw_pkg::SCREEN_W)
                 && (py >= 11'sd0) && (py < draw_pkg::SCREEN_H);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= C_IDLE;
            off_x  <= '0;
            off_y  <= '0;
            crit   <= '0;
            octant <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (start) begin
                        off_x  <= $signed({2'b00, radius});
                        off_y  <= '0;
                        crit   <= 12'sd1 - $signed({4'b0000, radius});
                        octant <= '0;
                        state  <= C_PLOT;
                    end
                end
                C_PLOT: begin
                    octant <= octant + 3'd1;
                    if (octant == 3'd7) begin
                        off_x <= next_x;
                        off_y <= next_y;
                        crit  <= next_crit;
                        // Stop once the octant boundary is crossed
                        if (next_y > next_x) begin
                            state <= C_DONE;
                        end
                    end
                end
                C_DONE: begin
                    if (!start) begin
                        state <= C_IDLE;
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // Off-screen points still take their cycle, just without a strobe
    assign pixel.x    = px[7:0];
    assign pixel.y    = py[6:0];
    assign pixel.plot = (state == C_PLOT) && on_screen;
    assign done       = (state == C_DONE);

endmodule

//--- logic/reuleaux_corners.sv
`timescale 1ns/1ps

module reuleaux_corners #(
    parameter int FRAC_BITS = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  draw_pkg::x_coord_t centre_x,
    input  draw_pkg::y_coord_t centre_y,
    input  draw_pkg::dim_t     diameter,
    output draw_pkg::corners_t corners
);

    // Room for the scaled centre plus the scaled offset and a sign
    localparam int W = FRAC_BITS + 12;

    localparam real    SQRT3   = 1.7320508075688772;
    localparam longint K6_FULL = longint'(SQRT3 / 6.0 * (2.0 ** FRAC_BITS));
    localparam longint K3_FULL = longint'(SQRT3 / 3.0 * (2.0 ** FRAC_BITS));
    localparam logic signed [W-1:0] K6 = K6_FULL[W-1:0];
    localparam logic signed [W-1:0] K3 = K3_FULL[W-1:0];

    logic signed [W-1:0] cy_scaled;
    logic signed [W-1:0] d_wide;
    logic signed [W-1:0] low_sum;
    logic signed [W-1:0] top_sum;
    logic signed [W-1:0] low_int;
    logic signed [W-1:0] top_int;
    draw_pkg::corners_t  next_corners;

    always_comb begin
        cy_scaled = $signed({{(W-7){1'b0}}, centre_y}) <<< FRAC_BITS;
        d_wide    = $signed({{(W-8){1'b0}}, diameter});

        // Base row of c1 and c2, then apex row of c3
        low_sum = cy_scaled + d_wide * K6;
        top_sum = cy_scaled - d_wide * K3;

        low_int = low_sum >>> FRAC_BITS;
        top_int = top_sum >>> FRAC_BITS;
        // Round up on the highest dropped bit
        if (low_sum[FRAC_BITS-1]) begin
            low_int = low_int + 1;
        end
        if (top_sum[FRAC_BITS-1]) begin
            top_int = top_int + 1;
        end

        next_corners.c1.x = $signed({1'b0, centre_x}) + $signed({2'b00, diameter[7:1]});
        next_corners.c1.y = low_int[7:0];
        next_corners.c2.x = $signed({1'b0, centre_x}) - $signed({2'b00, diameter[7:1]});
        next_corners.c2.y = low_int[7:0];
        next_corners.c3.x = $signed({1'b0, centre_x});
        next_corners.c3.y = top_int[7:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            corners <= '0;
        end else if (load) begin
            corners <= next_corners;
        end
    end

endmodule

//--- logic/reuleaux_fsm.sv
`timescale 1ns/1ps

module reuleaux_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  draw_pkg::colour_t colour,
    input  logic              fill_done,
    input  logic [2:0]        arc_done,
    output logic              fill_start,
    output logic              load_corners,
    output draw_pkg::arc_t    active_arc,
    output draw_pkg::colour_t draw_colour,
    output logic              done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FILL,
        S_LOAD,
        S_ARC1,
        S_ARC2,
        S_ARC3,
        S_DONE
    } seq_state_t;

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill_done) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_ARC1;
                end
                S_ARC1: begin
                    if (arc_done[0]) begin
                        state <= S_ARC2;
                    end
                end
                S_ARC2: begin
                    if (arc_done[1]) begin
                        state <= S_ARC3;
                    end
                end
                S_ARC3: begin
                    if (arc_done[2]) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    // Wait for the requester to drop start
                    if (!start) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Colour is frozen for the whole drawing
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            draw_colour <= colour;
        end
    end

    always_comb begin
        case (state)
            S_ARC1:  active_arc = draw_pkg::ARC_1;
            S_ARC2:  active_arc = draw_pkg::ARC_2;
            S_ARC3:  active_arc = draw_pkg::ARC_3;
            default: active_arc = draw_pkg::ARC_NONE;
        endcase
    end

    assign fill_start   = (state == S_FILL);
    assign load_corners = (state == S_LOAD);
    assign done         = (state == S_DONE);

endmodule

//--- logic/reuleaux.sv
`timescale 1ns/1ps

module reuleaux #(
    parameter int FRAC_BITS = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  draw_pkg::colour_t  colour,
    input  draw_pkg::x_coord_t centre_x,
    input  draw_pkg::y_coord_t centre_y,
    input  draw_pkg::dim_t     diameter,
    output logic               done,
    output draw_pkg::colour_t  vga_colour,
    output draw_pkg::pixel_t   pixel
);

    logic                fill_start;
    logic                fill_done;
    logic                load_corners;
    logic [2:0]          arc_start;
    logic [2:0]          arc_done;
    draw_pkg::arc_t      active_arc;
    draw_pkg::colour_t   draw_colour;
    draw_pkg::pixel_t    fill_pixel;
    draw_pkg::pixel_t    arc_pixel [3];
    draw_pkg::corner_t   arc_centre [3];
    draw_pkg::corners_t  corners;
    draw_pkg::pixel_t    sel_pixel;
    draw_pkg::corner_x_t sel_x;
    draw_pkg::corner_y_t sel_y;
    logic                keep;

    reuleaux_fsm reuleaux_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .colour       (colour),
        .fill_done    (fill_done),
        .arc_done     (arc_done),
        .fill_start   (fill_start),
        .load_corners (load_corners),
        .active_arc   (active_arc),
        .draw_colour  (draw_colour),
        .done         (done)
    );

    fillscreen fillscreen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .start (fill_start),
        .done  (fill_done),
        .pixel (fill_pixel)
    );

    reuleaux_corners #(
        .FRAC_BITS (FRAC_BITS)
    ) reuleaux_corners_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load_corners),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .diameter (diameter),
        .corners  (corners)
    );

    assign arc_centre[0] = corners.c1;
    assign arc_centre[1] = corners.c2;
    assign arc_centre[2] = corners.c3;

    assign arc_start[0] = (active_arc == draw_pkg::ARC_1);
    assign arc_start[1] = (active_arc == draw_pkg::ARC_2);
    assign arc_start[2] = (active_arc == draw_pkg::ARC_3);

    // One circle per arc, radius equals the diameter
    for (genvar i = 0; i < 3; i++) begin : g_arc
        circle circle_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .start  (arc_start[i]),
            .centre (arc_centre[i]),
            .radius (diameter),
            .done   (arc_done[i]),
            .pixel  (arc_pixel[i])
        );
    end

    // Pick the running circle and clip it to its arc of the outline
    always_comb begin
        case (active_arc)
            draw_pkg::ARC_1: sel_pixel = arc_pixel[0];
            draw_pkg::ARC_2: sel_pixel = arc_pixel[1];
            draw_pkg::ARC_3: sel_pixel = arc_pixel[2];
            default:         sel_pixel = '0;
        endcase
        sel_x = $signed({1'b0, sel_pixel.x});
        sel_y = $signed({1'b0, sel_pixel.y});
        case (active_arc)
            draw_pkg::ARC_1: keep = (sel_x <= corners.c3.x) && (sel_y <= corners.c1.y);
            draw_pkg::ARC_2: keep = (sel_x >= corners.c3.x) && (sel_y <= corners.c1.y);
            draw_pkg::ARC_3: keep = (sel_x >= corners.c2.x) && (sel_x <= corners.c1.x)
                                 && (sel_y >= corners.c1.y);
            default:         keep = 1'b0;
        endcase
    end

    // Clear in black, outline in the latched colour
    always_comb begin
        if (active_arc == draw_pkg::ARC_NONE) begin
            pixel      = fill_pixel;
            vga_colour = '0;
        end else begin
            pixel      = sel_pixel;
            pixel.plot = sel_pixel.plot & keep;
            vga_colour = draw_colour;
        end
    end

endmodule

//--- testbench/tb_reuleaux.sv
`timescale 1ns/1ps

module tb_reuleaux;

    localparam int NUM_DRAWS   = 6;
    localparam int FILL_COUNT  = draw_pkg::SCREEN_W * draw_pkg::SCREEN_H;
    // Worst case for one circle of the largest diameter, with margin
    localparam int ARC_BOUND   = 1500;
    localparam int CYCLE_LIMIT = NUM_DRAWS * (FILL_COUNT + 3 * ARC_BOUND + 100);
    // round(sqrt(3) / 6 * 2^16) and round(sqrt(3) / 3 * 2^16)
    localparam longint K6 = 18919;
    localparam longint K3 = 37837;

    logic               clk;
    logic               rst_n;
    logic               start;
    draw_pkg::colour_t  colour;
    draw_pkg::x_coord_t centre_x;
    draw_pkg::y_coord_t centre_y;
    draw_pkg::dim_t     diameter;
    logic               done;
    draw_pkg::colour_t  vga_colour;
    draw_pkg::pixel_t   pixel;

    int    cycle_count;
    string test_name;

    reuleaux reuleaux_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .done       (done),
        .vga_colour (vga_colour),
        .pixel      (pixel)
    );

    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout after %0d cycles, the DUT seems to hang",
                                     cycle_count));
        end
    end

    task automatic check_pixel(input string name, input draw_pkg::pixel_t expected,
                               input draw_pkg::pixel_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: expected x=%0d y=%0d plot=%0b actual x=%0d y=%0d plot=%0b",
                                     name, expected.x, expected.y, expected.plot,
                                     actual.x, actual.y, actual.plot));
        end
    endtask

    task automatic check_colour(input string name, input draw_pkg::colour_t expected,
                                input draw_pkg::colour_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR %s: expected %b actual %b", name, expected, actual));
        end
    endtask

    // Round half up after dropping 16 fraction bits
    function automatic int round_fixed(input longint value);
        return int'((value + 64'sd32768) >>> 16);
    endfunction

    function automatic draw_pkg::corners_t model_corners(input int cx, input int cy, input int d);
        draw_pkg::corners_t c;
        int                 base_y;
        int                 apex_y;
        base_y = round_fixed(longint'(cy) * 65536 + longint'(d) * K6);
        apex_y = round_fixed(longint'(cy) * 65536 - longint'(d) * K3);
        c.c1.x = draw_pkg::corner_x_t'(cx + d / 2);
        c.c1.y = draw_pkg::corner_y_t'(base_y);
        c.c2.x = draw_pkg::corner_x_t'(cx - d / 2);
        c.c2.y = draw_pkg::corner_y_t'(base_y);
        c.c3.x = draw_pkg::corner_x_t'(cx);
        c.c3.y = draw_pkg::corner_y_t'(apex_y);
        return c;
    endfunction

    // Clip region of one arc plus the distance band around radius d
    function automatic bit arc_fits(input int arc, input draw_pkg::corners_t c, input int x,
                                    input int y, input int d);
        int ax;
        int ay;
        bit clip;
        int err;
        case (arc)
            0: begin
                ax   = c.c1.x;
                ay   = c.c1.y;
                clip = (x <= c.c3.x) && (y <= c.c1.y);
            end
            1: begin
                ax   = c.c2.x;
                ay   = c.c2.y;
                clip = (x >= c.c3.x) && (y <= c.c1.y);
            end
            default: begin
                ax   = c.c3.x;
                ay   = c.c3.y;
                clip = (x >= c.c2.x) && (x <= c.c1.x) && (y >= c.c1.y);
            end
        endcase
        err = (x - ax) * (x - ax) + (y - ay) * (y - ay) - d * d;
        return clip && (err <= 2 * d + 1) && (err >= -(2 * d + 1));
    endfunction

    // Arc middle, away from the other two arcs, with a small screen margin
    function automatic bit middle_visible(input int arc, input draw_pkg::corners_t c, input int d);
        int mx;
        int my;
        case (arc)
            0: begin
                mx = c.c1.x - (d * 7) / 8;
                my = c.c1.y - d / 2;
            end
            1: begin
                mx = c.c2.x + (d * 7) / 8;
                my = c.c2.y - d / 2;
            end
            default: begin
                mx = c.c3.x;
                my = c.c3.y + d;
            end
        endcase
        return (mx >= 2) && (mx < draw_pkg::SCREEN_W - 2) && (my >= 2)
            && (my < draw_pkg::SCREEN_H - 2);
    endfunction

    task automatic run_drawing(input int index, input int d);
        int                 cx;
        int                 cy;
        int                 fill_seen;
        int                 arc_seen;
        int                 fit_count;
        int                 fit_arc;
        int                 own_hits [3];
        draw_pkg::corners_t model;
        draw_pkg::colour_t  expected_colour;
        draw_pkg::pixel_t   expected;
        cx        = $urandom_range(draw_pkg::SCREEN_W - 1, 0);
        cy        = $urandom_range(100, 20);
        test_name = $sformatf("draw%0d", index);
        model     = model_corners(cx, cy, d);
        fill_seen = 0;
        arc_seen  = 0;
        for (int k = 0; k < 3; k++) begin
            own_hits[k] = 0;
        end

        centre_x        = draw_pkg::x_coord_t'(cx);
        centre_y        = draw_pkg::y_coord_t'(cy);
        diameter        = draw_pkg::dim_t'(d);
        colour          = draw_pkg::colour_t'($urandom);
        start           = 1'b1;
        expected_colour = colour;

        do begin
            @(negedge clk);
            if (pixel.plot && fill_seen < FILL_COUNT) begin
                expected.x    = draw_pkg::x_coord_t'(fill_seen / draw_pkg::SCREEN_H);
                expected.y    = draw_pkg::y_coord_t'(fill_seen % draw_pkg::SCREEN_H);
                expected.plot = 1'b1;
                check_pixel({test_name, " clear pixel"}, expected, pixel);
                check_colour({test_name, " clear colour"}, draw_pkg::colour_t'(0), vga_colour);
                fill_seen++;
                // Colour changes mid-draw must not reach the outline
                if (fill_seen == FILL_COUNT / 2) begin
                    colour = colour + 3'd1;
                end
            end else if (pixel.plot) begin
                check_colour({test_name, " arc colour"}, expected_colour, vga_colour);
                check_bit({test_name, " arc pixel on screen"}, 1'b1,
                          (pixel.x < draw_pkg::SCREEN_W) && (pixel.y < draw_pkg::SCREEN_H));
                fit_count = 0;
                fit_arc   = 0;
                for (int k = 0; k < 3; k++) begin
                    if (arc_fits(k, model, pixel.x, pixel.y, d)) begin
                        fit_count++;
                        fit_arc = k;
                    end
                end
                check_bit({test_name, " arc geometry"}, 1'b1, fit_count > 0);
                if (fit_count == 1) begin
                    own_hits[fit_arc]++;
                end
                if (d == 0) begin
                    expected.x    = draw_pkg::x_coord_t'(cx);
                    expected.y    = draw_pkg::y_coord_t'(cy);
                    expected.plot = 1'b1;
                    check_pixel({test_name, " zero diameter"}, expected, pixel);
                end
                arc_seen++;
                if (arc_seen == 1) begin
                    colour = colour + 3'd1;
                end
            end
        end while (!done);

        check_bit({test_name, " plot with done"}, 1'b0, pixel.plot);
        if (fill_seen != FILL_COUNT) begin
            report_failure($sformatf("ERR %s clear count: expected %0d actual %0d",
                                     test_name, FILL_COUNT, fill_seen));
        end
        for (int k = 0; k < 3; k++) begin
            if (d != 0 && middle_visible(k, model, d) && own_hits[k] == 0) begin
                report_failure($sformatf("In %s arc %0d drew no pixel of its own",
                                         test_name, k + 1));
            end
        end

        // done must hold while start stays high
        repeat (3) begin
            @(negedge clk);
            check_bit({test_name, " done held"}, 1'b1, done);
            check_bit({test_name, " idle plot"}, 1'b0, pixel.plot);
        end
        start = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit({test_name, " plot after release"}, 1'b0, pixel.plot);
        end
        check_bit({test_name, " done after release"}, 1'b0, done);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        colour      = '0;
        centre_x    = '0;
        centre_y    = '0;
        diameter    = '0;
        cycle_count = 0;
        test_name   = "reset";
        void'($urandom(32));

        repeat (4) begin
            @(negedge clk);
            check_bit("reset plot", 1'b0, pixel.plot);
            check_bit("reset done", 1'b0, done);
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("idle plot", 1'b0, pixel.plot);
            check_bit("idle done", 1'b0, done);
        end

        // Last drawing collapses the triangle to its centre
        for (int i = 1; i <= NUM_DRAWS; i++) begin
            run_drawing(i, (i == NUM_DRAWS) ? 0 : $urandom_range(60, 8));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- all.f
logic/draw_pkg.sv
logic/fillscreen.sv
logic/circle.sv
logic/reuleaux_corners.sv
logic/reuleaux_fsm.sv
logic/reuleaux.sv
testbench/tb_reuleaux.sv

//--- Bender.yml
package:
  name: reuleaux

sources:
  - logic/draw_pkg.sv
  - logic/fillscreen.sv
  - logic/circle.sv
  - logic/reuleaux_corners.sv
  - logic/reuleaux_fsm.sv
  - logic/reuleaux.sv
  - target: test
    files:
      - testbench/tb_reuleaux.sv
